/* hw/axi_lite_pkg.sv */
package axi_lite_pkg;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite channel widths
    ////////////////////////////////////////////////////////////

    // Byte address on AW and AR
    localparam int unsigned axi_addr_width = 32;

    // Full word on W and R, no byte lanes used
    localparam int unsigned axi_data_width = 32;

    ////////////////////////////////////////////////////////////
    // Response codes on BRESP and RRESP
    ////////////////////////////////////////////////////////////

    // Encoding as in the AXI spec
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,  // Normal access done
        resp_exokay = 2'b01,  // Exclusive ok, never issued here
        resp_slverr = 2'b10,  // Slave refused the access
        resp_decerr = 2'b11   // No register at that address
    } axi_resp_t;

endpackage

/* hw/local_bus_pkg.sv */
package local_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Local bus widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned lb_addr_width = 32;  // Same as AXI side
    localparam int unsigned lb_data_width = 32;

    ////////////////////////////////////////////////////////////
    // Register map of the bank
    ////////////////////////////////////////////////////////////

    // Byte offsets, one word apart
    localparam logic [lb_addr_width-1:0] reg_ctrl_offset  = 32'h0000_0000;
    localparam logic [lb_addr_width-1:0] reg_data0_offset = 32'h0000_0004;
    localparam logic [lb_addr_width-1:0] reg_data1_offset = 32'h0000_0008;
    localparam logic [lb_addr_width-1:0] reg_id_offset    = 32'h0000_000C;

    // Read-only ident word
    localparam logic [lb_data_width-1:0] reg_id_value = 32'h4C42_4131;

    // Any of these set means outside the four-word window
    localparam logic [lb_addr_width-1:0] reg_map_mask = 32'hFFFF_FFF0;

endpackage

/* hw/axi_lite_master.sv */
`timescale 1ns/1ps

module axi_lite_master (
    input  logic                                   clk,
    input  logic                                   reset,

    // Local bus, write side
    input  logic                                   lb_wreq,
    input  logic [local_bus_pkg::lb_addr_width-1:0] lb_waddr,
    input  logic [local_bus_pkg::lb_data_width-1:0] lb_wdata,
    output logic                                   lb_wbusy,
    output logic                                   lb_wdone,
    output axi_lite_pkg::axi_resp_t                lb_wresp,

    // Local bus, read side
    input  logic                                   lb_rreq,
    input  logic [local_bus_pkg::lb_addr_width-1:0] lb_raddr,
    output logic                                   lb_rbusy,
    output logic                                   lb_rfinish,
    output logic [local_bus_pkg::lb_data_width-1:0] lb_rdata,
    output axi_lite_pkg::axi_resp_t                lb_rresp,

    // AXI4-Lite write channels
    output logic [axi_lite_pkg::axi_addr_width-1:0] awaddr,
    output logic                                   awvalid,
    input  logic                                   awready,
    output logic [axi_lite_pkg::axi_data_width-1:0] wdata,
    output logic                                   wvalid,
    input  logic                                   wready,
    input  axi_lite_pkg::axi_resp_t                bresp,
    input  logic                                   bvalid,
    output logic                                   bready,

    // AXI4-Lite read channels
    output logic [axi_lite_pkg::axi_addr_width-1:0] araddr,
    output logic                                   arvalid,
    input  logic                                   arready,
    input  logic [axi_lite_pkg::axi_data_width-1:0] rdata,
    input  axi_lite_pkg::axi_resp_t                rresp,
    input  logic                                   rvalid,
    output logic                                   rready
);

    import axi_lite_pkg::*;

    // Write engine states
    typedef enum logic [1:0] {
        w_idle,       // Waiting for lb_wreq
        w_addr_data,  // AW and W outstanding
        w_resp        // Waiting on B
    } w_state_t;

    // Read engine states
    typedef enum logic [1:0] {
        r_idle,       // Waiting for lb_rreq
        r_addr,       // AR outstanding
        r_data        // Waiting on R
    } r_state_t;

    w_state_t w_state;
    r_state_t r_state;

    logic wr_accept;    // Write strobe taken this cycle
    logic rd_accept;    // Read strobe taken this cycle
    logic aw_accepted;  // Address side done or done now
    logic w_accepted;   // Data side done or done now

    // Strobes only count in idle, busy requests drop on the floor
    assign wr_accept = (w_state == w_idle) && lb_wreq;
    assign rd_accept = (r_state == r_idle) && lb_rreq;

    // A dropped valid means that channel already went through
    assign aw_accepted = ~awvalid | awready;
    assign w_accepted  = ~wvalid | wready;

    assign lb_wbusy = (w_state != w_idle);
    assign lb_rbusy = (r_state != r_idle);

    ////////////////////////////////////////////////////////////
    // Write engine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            w_state  <= w_idle;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bready   <= 1'b0;
            lb_wdone <= 1'b0;
            lb_wresp <= resp_okay;
        end else begin
            lb_wdone <= 1'b0;  // Single-cycle pulse
            case (w_state)
                w_idle: begin
                    if (wr_accept) begin
                        awvalid <= 1'b1;  // Both channels launched together
                        wvalid  <= 1'b1;
                        w_state <= w_addr_data;
                    end
                end
                w_addr_data: begin
                    if (awvalid && awready) awvalid <= 1'b0;  // AW done
                    if (wvalid && wready) wvalid <= 1'b0;     // W done
                    // Either order works, move on once both are through
                    if (aw_accepted && w_accepted) begin
                        bready  <= 1'b1;
                        w_state <= w_resp;
                    end
                end
                w_resp: begin
                    if (bvalid && bready) begin
                        bready   <= 1'b0;
                        lb_wresp <= bresp;  // Held until next write
                        lb_wdone <= 1'b1;
                        w_state  <= w_idle;
                    end
                end
                default: w_state <= w_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Read engine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            r_state    <= r_idle;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            lb_rfinish <= 1'b0;
            lb_rresp   <= resp_okay;
        end else begin
            lb_rfinish <= 1'b0;
            case (r_state)
                r_idle: begin
                    if (rd_accept) begin
                        arvalid <= 1'b1;
                        r_state <= r_addr;
                    end
                end
                r_addr: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;  // Open for R right after AR
                        r_state <= r_data;
                    end
                end
                r_data: begin
                    if (rvalid && rready) begin
                        rready     <= 1'b0;
                        lb_rresp   <= rresp;
                        lb_rfinish <= 1'b1;
                        r_state    <= r_idle;
                    end
                end
                default: r_state <= r_idle;
            endcase
        end
    end

    // Address, data and read return capture
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            awaddr <= lb_waddr;  // Sampled on the strobe
            wdata  <= lb_wdata;
        end
        if (rd_accept) araddr <= lb_raddr;
        if ((r_state == r_data) && rvalid && rready) lb_rdata <= rdata;
    end

endmodule

/* hw/axi_lite_reg_slave.sv */
`timescale 1ns/1ps

module axi_lite_reg_slave (
    input  logic                                   clk,
    input  logic                                   reset,

    // Write address and data
    input  logic [axi_lite_pkg::axi_addr_width-1:0] awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [axi_lite_pkg::axi_data_width-1:0] wdata,
    input  logic                                   wvalid,
    output logic                                   wready,

    // Write response
    output axi_lite_pkg::axi_resp_t                bresp,
    output logic                                   bvalid,
    input  logic                                   bready,

    // Read address and data
    input  logic [axi_lite_pkg::axi_addr_width-1:0] araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [axi_lite_pkg::axi_data_width-1:0] rdata,
    output axi_lite_pkg::axi_resp_t                rresp,
    output logic                                   rvalid,
    input  logic                                   rready
);

    import axi_lite_pkg::*;
    import local_bus_pkg::*;

    logic [axi_data_width-1:0] data_regs [0:2];  // ctrl, data0, data1

    logic wr_fire;  // AW and W taken this cycle
    logic rd_fire;  // AR taken this cycle

    // Ready pair only goes up with both valids, so one check covers both
    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    // Response for an access at addr
    function automatic axi_resp_t access_resp(
        input logic [axi_addr_width-1:0] addr,
        input logic                      is_write
    );
        if (((addr & reg_map_mask) != '0) || (addr[1:0] != 2'b00)) begin
            return resp_decerr;  // Outside window or unaligned
        end else if (is_write && (addr == reg_id_offset)) begin
            return resp_slverr;  // ID word is read-only
        end else begin
            return resp_okay;
        end
    endfunction

    // Read mux, zero for anything unmapped
    function automatic logic [axi_data_width-1:0] read_value(
        input logic [axi_addr_width-1:0] addr
    );
        case (addr)
            reg_ctrl_offset:  return data_regs[0];
            reg_data0_offset: return data_regs[1];
            reg_data1_offset: return data_regs[2];
            reg_id_offset:    return reg_id_value;
            default:          return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                data_regs[i] <= '0;
            end
        end else begin
            // One-cycle ready pulse, held off while B is pending
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;

            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)  // Only matches on legal offsets
                    reg_ctrl_offset:  data_regs[0] <= wdata;
                    reg_data0_offset: data_regs[1] <= wdata;
                    reg_data1_offset: data_regs[2] <= wdata;
                    default: ;        // ID or bad address, nothing stored
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;  // Registered accept

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, captured with the address transfer
    always_ff @(posedge clk) begin
        if (wr_fire) bresp <= access_resp(awaddr, 1'b1);
        if (rd_fire) begin
            rresp <= access_resp(araddr, 1'b0);
            rdata <= read_value(araddr);
        end
    end

endmodule

/* hw/lb_axi_subsystem.sv */
`timescale 1ns/1ps

module lb_axi_subsystem (
    input  logic                                   clk,
    input  logic                                   reset,

    // Local bus write
    input  logic                                   lb_wreq,
    input  logic [local_bus_pkg::lb_addr_width-1:0] lb_waddr,
    input  logic [local_bus_pkg::lb_data_width-1:0] lb_wdata,
    output logic                                   lb_wbusy,
    output logic                                   lb_wdone,
    output axi_lite_pkg::axi_resp_t                lb_wresp,

    // Local bus read
    input  logic                                   lb_rreq,
    input  logic [local_bus_pkg::lb_addr_width-1:0] lb_raddr,
    output logic                                   lb_rbusy,
    output logic                                   lb_rfinish,
    output logic [local_bus_pkg::lb_data_width-1:0] lb_rdata,
    output axi_lite_pkg::axi_resp_t                lb_rresp
);

    import axi_lite_pkg::*;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite wires, master to register bank
    ////////////////////////////////////////////////////////////

    logic [axi_addr_width-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [axi_data_width-1:0] wdata;
    logic                      wvalid;
    logic                      wready;
    axi_resp_t                 bresp;
    logic                      bvalid;
    logic                      bready;
    logic [axi_addr_width-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [axi_data_width-1:0] rdata;
    axi_resp_t                 rresp;
    logic                      rvalid;
    logic                      rready;

    // Bridge from strobes to AXI
    axi_lite_master master_i (
        .clk        (clk),
        .reset      (reset),
        .lb_wreq    (lb_wreq),
        .lb_waddr   (lb_waddr),
        .lb_wdata   (lb_wdata),
        .lb_wbusy   (lb_wbusy),
        .lb_wdone   (lb_wdone),
        .lb_wresp   (lb_wresp),
        .lb_rreq    (lb_rreq),
        .lb_raddr   (lb_raddr),
        .lb_rbusy   (lb_rbusy),
        .lb_rfinish (lb_rfinish),
        .lb_rdata   (lb_rdata),
        .lb_rresp   (lb_rresp),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    // Register bank
    axi_lite_reg_slave slave_i (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

/* sim/lb_axi_assertions.sv */
`timescale 1ns/1ps

module lb_axi_assertions (
    input logic clk,
    input logic reset,
    input logic lb_wreq,
    input logic lb_wbusy,
    input logic lb_wdone,
    input logic lb_rreq,
    input logic lb_rbusy,
    input logic lb_rfinish,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rready
);

    int fail_count = 0;  // Failed assertions so far

    task automatic record_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    ////////////////////////////////////////////////////////////
    // Local bus completion timing
    ////////////////////////////////////////////////////////////

    // Strobe taken while idle gives a pulse exactly four cycles on
    write_latency: assert property (@(posedge clk) disable iff (reset)
        lb_wreq && !lb_wbusy |-> ##4 lb_wdone)
        else record_failure("Write done pulse not four cycles after the request");
    read_latency: assert property (@(posedge clk) disable iff (reset)
        lb_rreq && !lb_rbusy |-> ##4 lb_rfinish)
        else record_failure("Read finish pulse not four cycles after the request");

    // Engines stay quiet while reset is held
    reset_idle: assert property (@(posedge clk)
        reset |=> !lb_wbusy && !lb_rbusy && !lb_wdone && !lb_rfinish)
        else record_failure("Busy or completion output active during reset");

    ////////////////////////////////////////////////////////////
    // AXI valid held until ready
    ////////////////////////////////////////////////////////////

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else record_failure("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid)
        else record_failure("wvalid dropped before wready");

    // B and R valids rise together with their ready, so only a fall is checked
    b_hold: assert property (@(posedge clk) disable iff (reset)
        $fell(bvalid) |-> $past(bready))
        else record_failure("bvalid dropped before bready");
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else record_failure("arvalid dropped before arready");
    r_hold: assert property (@(posedge clk) disable iff (reset)
        $fell(rvalid) |-> $past(rready))
        else record_failure("rvalid dropped before rready");

endmodule

// Hooked onto the top level with AXI wires picked up by name
bind lb_axi_subsystem lb_axi_assertions assertions_i (.*);

/* sim/tb_lb_axi_subsystem.sv */
`timescale 1ns/1ps

module tb_lb_axi_subsystem;

    import axi_lite_pkg::*;
    import local_bus_pkg::*;

    localparam int num_transactions = 33;  // Reads plus writes, all tests
    localparam int done_limit = 12;         // Cycles allowed per completion

    logic                     clk;
    logic                     reset;
    logic                     lb_wreq;
    logic [lb_addr_width-1:0] lb_waddr;
    logic [lb_data_width-1:0] lb_wdata;
    logic                     lb_wbusy;
    logic                     lb_wdone;
    axi_resp_t                lb_wresp;
    logic                     lb_rreq;
    logic [lb_addr_width-1:0] lb_raddr;
    logic                     lb_rbusy;
    logic                     lb_rfinish;
    logic [lb_data_width-1:0] lb_rdata;
    axi_resp_t                lb_rresp;

    logic [lb_data_width-1:0] model_regs [0:2];  // ctrl, data0, data1
    int err_count = 0;
    int seed = 32'hf83c0f0b;

    lb_axi_subsystem dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Hang guard
    initial begin
        repeat (num_transactions * 6 + 50) @(posedge clk);
        $display("Watchdog expired, the test sequence did not complete");
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Checks and bus tasks
    ////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        assert (got === exp) else begin
            err_count++;
            $display("error at %0d ns: %s = %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    // Step clocks until the wanted completions have pulsed
    task automatic wait_done(input logic want_w, input logic want_r);
        logic got_w;
        logic got_r;
        int n;
        got_w = !want_w;
        got_r = !want_r;
        n = 0;
        while (!(got_w && got_r) && n < done_limit) begin
            @(posedge clk);
            #1;  // Registered outputs settled
            got_w = got_w | lb_wdone;
            got_r = got_r | lb_rfinish;
            n++;
        end
        if (!(got_w && got_r)) begin
            err_count++;
            $display("Local bus request did not complete within %0d cycles", done_limit);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input axi_resp_t exp_resp);
        lb_wreq  = 1'b1;
        lb_waddr = addr;
        lb_wdata = data;
        @(posedge clk);
        #1;
        lb_wreq = 1'b0;  // One-cycle strobe
        wait_done(1'b1, 1'b0);
        check_resp("lb_wresp", lb_wresp, exp_resp);
        if (exp_resp == resp_okay) model_regs[addr[3:2]] = data;  // Only legal stores land
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
                            input axi_resp_t exp_resp);
        lb_rreq  = 1'b1;
        lb_raddr = addr;
        @(posedge clk);
        #1;
        lb_rreq = 1'b0;
        wait_done(1'b0, 1'b1);
        check_data("lb_rdata", lb_rdata, exp_data);
        check_resp("lb_rresp", lb_rresp, exp_resp);
    endtask

    // Write data0 and read data1 together, then strobe again while busy
    task automatic overlap_and_drop();
        logic [31:0] new_val;
        new_val  = $random(seed);
        lb_wreq  = 1'b1;
        lb_waddr = reg_data0_offset;
        lb_wdata = new_val;
        lb_rreq  = 1'b1;
        lb_raddr = reg_data1_offset;
        @(posedge clk);
        #1;
        assert (lb_wbusy && lb_rbusy) else begin
            err_count++;
            $display("Engines not busy after taking a write and a read");
        end
        lb_waddr = reg_data1_offset;  // Must be ignored
        lb_wdata = ~new_val;
        lb_raddr = reg_id_offset;
        @(posedge clk);
        #1;
        lb_wreq = 1'b0;
        lb_rreq = 1'b0;
        wait_done(1'b1, 1'b1);
        check_resp("lb_wresp", lb_wresp, resp_okay);
        check_data("lb_rdata", lb_rdata, model_regs[2]);
        check_resp("lb_rresp", lb_rresp, resp_okay);
        model_regs[1] = new_val;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        int idx;
        reset    = 1'b1;
        lb_wreq  = 1'b0;
        lb_waddr = '0;
        lb_wdata = '0;
        lb_rreq  = 1'b0;
        lb_raddr = '0;
        for (int i = 0; i < 3; i++) model_regs[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Cleared registers and ID word
        read_reg(reg_ctrl_offset, model_regs[0], resp_okay);
        read_reg(reg_data0_offset, model_regs[1], resp_okay);
        read_reg(reg_data1_offset, model_regs[2], resp_okay);
        read_reg(reg_id_offset, reg_id_value, resp_okay);

        // Random write, read back
        for (int i = 0; i < 8; i++) begin
            idx  = $unsigned($random(seed)) % 3;
            addr = idx * 4;
            data = $random(seed);
            write_reg(addr, data, resp_okay);
            read_reg(addr, model_regs[idx], resp_okay);
        end

        // ID is read-only
        write_reg(reg_id_offset, $random(seed), resp_slverr);
        read_reg(reg_id_offset, reg_id_value, resp_okay);

        // Out of window and unaligned
        addr = $random(seed) | 32'h10;
        write_reg(addr, $random(seed), resp_decerr);
        addr = (($unsigned($random(seed)) % 3) * 4) + 1 + ($unsigned($random(seed)) % 3);
        write_reg(addr, $random(seed), resp_decerr);
        read_reg($random(seed) | 32'h100, '0, resp_decerr);
        read_reg(addr, '0, resp_decerr);
        for (int i = 0; i < 3; i++) read_reg(i * 4, model_regs[i], resp_okay);

        // Concurrent engines, busy strobes dropped
        overlap_and_drop();
        read_reg(reg_data0_offset, model_regs[1], resp_okay);
        read_reg(reg_data1_offset, model_regs[2], resp_okay);

        $display("Data check errors: %0d, assertion failures: %0d", err_count,
                 dut_i.assertions_i.fail_count);
        if (err_count == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* list.f */
hw/axi_lite_pkg.sv
hw/local_bus_pkg.sv
hw/axi_lite_master.sv
hw/axi_lite_reg_slave.sv
hw/lb_axi_subsystem.sv
sim/lb_axi_assertions.sv
sim/tb_lb_axi_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --assert --timescale 1ns/1ps -f list.f \
        --top-module tb_lb_axi_subsystem -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
